// ==== hw/muldiv_pkg.sv ====
// shared types for the multiply/divide coprocessor
// opcodes, unit handshake structs, APB structs, register map and status word

package muldiv_pkg;

  // --------------------
  // sizes
  // --------------------

  // one result bit (div) or one partial product (mul) per step
  localparam int NUM_STEPS = 32;
  // step counter has to reach NUM_STEPS itself
  localparam int CNT_W = $clog2(NUM_STEPS + 1);
  localparam int NUM_SLOTS = 4;

  // --------------------
  // register map
  // --------------------

  localparam logic [7:0] ADDR_OPA = 8'h00;
  localparam logic [7:0] ADDR_OPB = 8'h04;
  localparam logic [7:0] ADDR_CMD = 8'h08;
  localparam logic [7:0] ADDR_STATUS = 8'h0C;
  // slot n: low word at base + 8n, high word at base + 8n + 4
  localparam logic [7:0] ADDR_RES_BASE = 8'h20;

  // --------------------
  // types
  // --------------------

  // bit 1 picks the unit, bit 0 marks a signed op
  typedef enum logic [1:0] {
    OP_MULU = 2'd0,
    OP_MUL  = 2'd1,
    OP_DIVU = 2'd2,
    OP_DIV  = 2'd3
  } muldiv_op_e;

  // control states shared by both iterative units
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } unit_state_e;

  typedef logic [1:0] tag_t;

  typedef struct packed {
    muldiv_op_e  op;
    tag_t        tag;
    logic [31:0] a;
    logic [31:0] b;
  } unit_req_t;

  // div: remainder in [63:32], quotient in [31:0]
  typedef struct packed {
    tag_t        tag;
    logic [63:0] result;
  } unit_resp_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_resp_t;

  typedef struct packed {
    logic [23:0] rsvd_hi;
    logic [3:0]  slot_valid;
    logic [1:0]  rsvd_lo;
    logic        mul_busy;
    logic        div_busy;
  } status_t;

endpackage

// ==== hw/int_div_iterative.sv ====
// iterative restoring divider, 32 steps, signed and unsigned
// control FSM and shift/subtract datapath

`timescale 1ns/100ps

module int_div_iterative (
  input  logic                   clk,
  input  logic                   reset,
  input  muldiv_pkg::unit_req_t  req,
  input  logic                   req_valid,
  output logic                   req_ready,
  output muldiv_pkg::unit_resp_t resp,
  output logic                   resp_valid,
  input  logic                   resp_ready
);

  muldiv_pkg::unit_state_e        state;
  logic [muldiv_pkg::CNT_W-1:0]   count;
  logic                           last_step;

  // remainder in the upper part, quotient shifts in from the bottom
  logic [64:0]                    rq;
  logic [31:0]                    divisor;
  muldiv_pkg::tag_t               tag_q;
  logic                           sign_a;
  logic                           sign_b;

  logic                           is_signed;
  logic [31:0]                    a_mag;
  logic [31:0]                    b_mag;
  logic [64:0]                    rq_shift;
  logic [64:0]                    sub_out;
  logic [64:0]                    rq_step;
  logic [31:0]                    quot_fix;
  logic [31:0]                    rem_fix;

  // --------------------
  // operand conditioning
  // --------------------

  assign is_signed = (req.op == muldiv_pkg::OP_DIV);
  // signed op divides magnitudes, the signs are fixed up at the end
  assign a_mag = (is_signed && req.a[31]) ? -req.a : req.a;
  assign b_mag = (is_signed && req.b[31]) ? -req.b : req.b;

  // --------------------
  // one restoring step
  // --------------------

  assign rq_shift = {rq[63:0], 1'b0};
  assign sub_out = rq_shift - {1'b0, divisor, 32'b0};
  // negative difference means restore, quotient bit stays zero
  assign rq_step = sub_out[64] ? rq_shift : {sub_out[64:1], 1'b1};

  // quotient keeps all ones on a zero divisor
  assign quot_fix = ((sign_a ^ sign_b) && (divisor != 32'd0)) ? -rq[31:0] : rq[31:0];
  // remainder follows the dividend sign
  assign rem_fix = sign_a ? -rq[63:32] : rq[63:32];

  assign last_step = (count == muldiv_pkg::CNT_W'(muldiv_pkg::NUM_STEPS));

  // --------------------
  // control FSM
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= muldiv_pkg::IDLE;
      count <= '0;
    end else begin
      case (state)
        muldiv_pkg::IDLE: begin
          // req_ready is high here, so valid alone is the transfer
          if (req_valid) begin
            state <= muldiv_pkg::CALC;
            count <= '0;
          end
        end
        muldiv_pkg::CALC: begin
          // one extra cycle after the last step for the sign fixup
          if (last_step) begin
            state <= muldiv_pkg::DONE;
          end else begin
            count <= count + 1'b1;
          end
        end
        muldiv_pkg::DONE: begin
          if (resp_ready) begin
            state <= muldiv_pkg::IDLE;
          end
        end
        default: begin
          state <= muldiv_pkg::IDLE;
        end
      endcase
    end
  end

  // datapath registers
  always_ff @(posedge clk) begin
    if (state == muldiv_pkg::IDLE && req_valid) begin
      rq <= {33'b0, a_mag};
      divisor <= b_mag;
      sign_a <= is_signed && req.a[31];
      sign_b <= is_signed && req.b[31];
      tag_q <= req.tag;
    end else if (state == muldiv_pkg::CALC) begin
      if (last_step) begin
        rq <= {1'b0, rem_fix, quot_fix};
      end else begin
        rq <= rq_step;
      end
    end
  end

  assign req_ready = (state == muldiv_pkg::IDLE);
  assign resp_valid = (state == muldiv_pkg::DONE);
  assign resp = '{tag: tag_q, result: rq[63:0]};

  // a stalled response must not change under the arbiter
  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp));

endmodule

// ==== hw/int_mul_iterative.sv ====
// iterative shift-add multiplier, 32 steps, signed and unsigned

`timescale 1ns/100ps

module int_mul_iterative (
  input  logic                   clk,
  input  logic                   reset,
  input  muldiv_pkg::unit_req_t  req,
  input  logic                   req_valid,
  output logic                   req_ready,
  output muldiv_pkg::unit_resp_t resp,
  output logic                   resp_valid,
  input  logic                   resp_ready
);

  muldiv_pkg::unit_state_e        state;
  logic [muldiv_pkg::CNT_W-1:0]   count;
  logic                           last_step;

  logic [63:0]                    acc;
  // multiplicand moves left, multiplier moves right
  logic [63:0]                    mcand;
  logic [31:0]                    mplier;
  muldiv_pkg::tag_t               tag_q;
  logic                           neg_q;

  logic                           is_signed;
  logic [31:0]                    a_mag;
  logic [31:0]                    b_mag;

  assign is_signed = (req.op == muldiv_pkg::OP_MUL);
  assign a_mag = (is_signed && req.a[31]) ? -req.a : req.a;
  assign b_mag = (is_signed && req.b[31]) ? -req.b : req.b;

  assign last_step = (count == muldiv_pkg::CNT_W'(muldiv_pkg::NUM_STEPS));

  // control FSM, same step timing as the divider
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= muldiv_pkg::IDLE;
      count <= '0;
    end else begin
      case (state)
        muldiv_pkg::IDLE: begin
          if (req_valid) begin
            state <= muldiv_pkg::CALC;
            count <= '0;
          end
        end
        muldiv_pkg::CALC: begin
          if (last_step) begin
            state <= muldiv_pkg::DONE;
          end else begin
            count <= count + 1'b1;
          end
        end
        muldiv_pkg::DONE: begin
          if (resp_ready) begin
            state <= muldiv_pkg::IDLE;
          end
        end
        default: begin
          state <= muldiv_pkg::IDLE;
        end
      endcase
    end
  end

  // --------------------
  // accumulate datapath
  // --------------------

  always_ff @(posedge clk) begin
    if (state == muldiv_pkg::IDLE && req_valid) begin
      acc <= '0;
      mcand <= {32'b0, a_mag};
      mplier <= b_mag;
      neg_q <= is_signed && (req.a[31] ^ req.b[31]);
      tag_q <= req.tag;
    end else if (state == muldiv_pkg::CALC) begin
      if (last_step) begin
        // full 64-bit negate for mixed signs
        if (neg_q) begin
          acc <= -acc;
        end
      end else begin
        if (mplier[0]) begin
          acc <= acc + mcand;
        end
        mcand <= {mcand[62:0], 1'b0};
        mplier <= {1'b0, mplier[31:1]};
      end
    end
  end

  assign req_ready = (state == muldiv_pkg::IDLE);
  assign resp_valid = (state == muldiv_pkg::DONE);
  assign resp = '{tag: tag_q, result: acc};

  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp));

endmodule

// ==== hw/wb_arbiter.sv ====
// fixed-priority write-back arbiter, divider first

`timescale 1ns/100ps

module wb_arbiter (
  input  logic                   clk,
  input  logic                   reset,
  input  muldiv_pkg::unit_resp_t div_resp,
  input  logic                   div_valid,
  output logic                   div_ready,
  input  muldiv_pkg::unit_resp_t mul_resp,
  input  logic                   mul_valid,
  output logic                   mul_ready,
  output muldiv_pkg::unit_resp_t wb,
  output logic                   wb_valid
);

  // the result store never stalls, so a grant is just priority
  assign div_ready = div_valid;
  // multiplier gets the path whenever the divider is quiet
  assign mul_ready = mul_valid && !div_valid;

  assign wb = div_valid ? div_resp : mul_resp;
  assign wb_valid = div_valid || mul_valid;

  // --------------------
  // checks
  // --------------------

  // at most one unit drains per cycle
  a_one_grant: assert property (@(posedge clk) disable iff (reset)
    !(div_ready && mul_ready));

  // divider needs a full run before it is valid again
  // so a blocked multiplier drains on the very next cycle
  a_mul_wait: assert property (@(posedge clk) disable iff (reset)
    mul_valid && !mul_ready |=> mul_ready);

endmodule

// ==== hw/muldiv_apb_regs.sv ====
// APB register block: operands, command launch, status and result slots
// dispatches commands to the divider or multiplier and catches write-back

`timescale 1ns/100ps

module muldiv_apb_regs (
  input  logic                   clk,
  input  logic                   reset,
  input  muldiv_pkg::apb_req_t   apb_req,
  output muldiv_pkg::apb_resp_t  apb_resp,
  output muldiv_pkg::unit_req_t  div_req,
  output logic                   div_req_valid,
  input  logic                   div_req_ready,
  output muldiv_pkg::unit_req_t  mul_req,
  output logic                   mul_req_valid,
  input  logic                   mul_req_ready,
  input  muldiv_pkg::unit_resp_t wb,
  input  logic                   wb_valid
);

  logic [31:0]                       opa_q;
  logic [31:0]                       opb_q;
  // one payload register serves both units
  muldiv_pkg::unit_req_t             req_q;
  logic                              div_req_valid_q;
  logic                              mul_req_valid_q;

  logic [63:0]                       slot_data [muldiv_pkg::NUM_SLOTS];
  logic [muldiv_pkg::NUM_SLOTS-1:0]  slot_valid;
  muldiv_pkg::status_t               status;

  logic                              access;
  logic                              wr;
  logic                              hit_opa;
  logic                              hit_opb;
  logic                              hit_cmd;
  logic                              hit_status;
  logic                              hit_res;
  logic                              mapped;
  muldiv_pkg::muldiv_op_e            cmd_op;
  muldiv_pkg::tag_t                  cmd_tag;
  muldiv_pkg::tag_t                  res_tag;
  logic                              cmd_to_div;
  logic                              target_busy;
  logic                              cmd_accept;
  logic [31:0]                       rdata;

  // --------------------
  // address decode
  // --------------------

  // no wait states, everything happens in the access phase
  assign access = apb_req.psel && apb_req.penable;

  assign hit_opa = (apb_req.paddr == muldiv_pkg::ADDR_OPA);
  assign hit_opb = (apb_req.paddr == muldiv_pkg::ADDR_OPB);
  assign hit_cmd = (apb_req.paddr == muldiv_pkg::ADDR_CMD);
  assign hit_status = (apb_req.paddr == muldiv_pkg::ADDR_STATUS);
  // 0x20..0x3c, word aligned
  assign hit_res = (apb_req.paddr[7:5] == muldiv_pkg::ADDR_RES_BASE[7:5]) &&
                   (apb_req.paddr[1:0] == 2'b00);
  assign mapped = hit_opa || hit_opb || hit_cmd || hit_status || hit_res;
  assign res_tag = apb_req.paddr[4:3];

  assign wr = access && apb_req.pwrite;

  // command word: op in [1:0], tag in [5:4]
  assign cmd_op = muldiv_pkg::muldiv_op_e'(apb_req.pwdata[1:0]);
  assign cmd_tag = apb_req.pwdata[5:4];
  assign cmd_to_div = (cmd_op == muldiv_pkg::OP_DIVU) || (cmd_op == muldiv_pkg::OP_DIV);

  // a launch still in flight also counts as busy
  assign target_busy = cmd_to_div ? (!div_req_ready || div_req_valid_q) :
                                    (!mul_req_ready || mul_req_valid_q);
  assign cmd_accept = wr && hit_cmd && !target_busy;

  // --------------------
  // control state
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      div_req_valid_q <= 1'b0;
      mul_req_valid_q <= 1'b0;
      slot_valid <= '0;
    end else begin
      // launch pulse lasts one cycle, the unit is idle and takes it
      div_req_valid_q <= cmd_accept && cmd_to_div;
      mul_req_valid_q <= cmd_accept && !cmd_to_div;
      if (wb_valid) begin
        slot_valid[wb.tag] <= 1'b1;
      end
      // a new command on the same tag wins over a landing result
      if (cmd_accept) begin
        slot_valid[cmd_tag] <= 1'b0;
      end
    end
  end

  // operands, launched request and result slots
  always_ff @(posedge clk) begin
    if (wr && hit_opa) begin
      opa_q <= apb_req.pwdata;
    end
    if (wr && hit_opb) begin
      opb_q <= apb_req.pwdata;
    end
    if (cmd_accept) begin
      req_q <= '{op: cmd_op, tag: cmd_tag, a: opa_q, b: opb_q};
    end
    if (wb_valid) begin
      slot_data[wb.tag] <= wb.result;
    end
  end

  // --------------------
  // read path
  // --------------------

  assign status = '{rsvd_hi: '0, slot_valid: slot_valid, rsvd_lo: '0,
                    mul_busy: !mul_req_ready, div_busy: !div_req_ready};

  always_comb begin
    rdata = '0;
    if (hit_opa) begin
      rdata = opa_q;
    end else if (hit_opb) begin
      rdata = opb_q;
    end else if (hit_cmd) begin
      // last accepted command
      rdata = {26'b0, req_q.tag, 2'b00, req_q.op};
    end else if (hit_status) begin
      rdata = status;
    end else if (hit_res) begin
      rdata = apb_req.paddr[2] ? slot_data[res_tag][63:32] : slot_data[res_tag][31:0];
    end
  end

  assign apb_resp = '{prdata: rdata, pready: 1'b1,
                      pslverr: access && (!mapped || (wr && hit_cmd && target_busy))};

  assign div_req = req_q;
  assign mul_req = req_q;
  assign div_req_valid = div_req_valid_q;
  assign mul_req_valid = mul_req_valid_q;

  // launches only ever go to an idle unit
  a_div_launch: assert property (@(posedge clk) disable iff (reset)
    div_req_valid |-> div_req_ready);
  a_mul_launch: assert property (@(posedge clk) disable iff (reset)
    mul_req_valid |-> mul_req_ready);

endmodule

// ==== hw/muldiv_top.sv ====
// coprocessor top: register block, both units and the write-back arbiter

`timescale 1ns/100ps

module muldiv_top (
  input  logic                  clk,
  input  logic                  reset,
  input  muldiv_pkg::apb_req_t  apb_req,
  output muldiv_pkg::apb_resp_t apb_resp
);

  // request side
  muldiv_pkg::unit_req_t  div_req;
  logic                   div_req_valid;
  logic                   div_req_ready;
  muldiv_pkg::unit_req_t  mul_req;
  logic                   mul_req_valid;
  logic                   mul_req_ready;

  // response side
  muldiv_pkg::unit_resp_t div_resp;
  logic                   div_resp_valid;
  logic                   div_resp_ready;
  muldiv_pkg::unit_resp_t mul_resp;
  logic                   mul_resp_valid;
  logic                   mul_resp_ready;
  muldiv_pkg::unit_resp_t wb;
  logic                   wb_valid;

  muldiv_apb_regs regs_i (
    .clk           (clk),
    .reset         (reset),
    .apb_req       (apb_req),
    .apb_resp      (apb_resp),
    .div_req       (div_req),
    .div_req_valid (div_req_valid),
    .div_req_ready (div_req_ready),
    .mul_req       (mul_req),
    .mul_req_valid (mul_req_valid),
    .mul_req_ready (mul_req_ready),
    .wb            (wb),
    .wb_valid      (wb_valid)
  );

  int_div_iterative div_i (
    .clk        (clk),
    .reset      (reset),
    .req        (div_req),
    .req_valid  (div_req_valid),
    .req_ready  (div_req_ready),
    .resp       (div_resp),
    .resp_valid (div_resp_valid),
    .resp_ready (div_resp_ready)
  );

  int_mul_iterative mul_i (
    .clk        (clk),
    .reset      (reset),
    .req        (mul_req),
    .req_valid  (mul_req_valid),
    .req_ready  (mul_req_ready),
    .resp       (mul_resp),
    .resp_valid (mul_resp_valid),
    .resp_ready (mul_resp_ready)
  );

  wb_arbiter arb_i (
    .clk       (clk),
    .reset     (reset),
    .div_resp  (div_resp),
    .div_valid (div_resp_valid),
    .div_ready (div_resp_ready),
    .mul_resp  (mul_resp),
    .mul_valid (mul_resp_valid),
    .mul_ready (mul_resp_ready),
    .wb        (wb),
    .wb_valid  (wb_valid)
  );

endmodule

// ==== tb/tb_clk_gen.sv ====
// testbench clock (10 ns period) and power-on reset held for 8 cycles

`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // release 1 ns after the 8th edge, like every other input
  initial begin
    reset = 1'b1;
    repeat (8) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

// ==== tb/tb_muldiv.sv ====
// directed tests for the APB multiply/divide coprocessor
// APB driver tasks, LFSR operands, reference model, compare tasks, timeout

`timescale 1ns/100ps

module tb_muldiv;

  // every command write, accepted or rejected, counted once
  localparam int NUM_CMDS = 37;
  localparam int TIMEOUT_CYCLES = NUM_CMDS * 40 + 200;

  logic                  clk;
  logic                  reset;
  muldiv_pkg::apb_req_t  apb_req;
  muldiv_pkg::apb_resp_t apb_resp;

  logic [31:0]           lfsr_state = 32'ha1f9_5fc5;
  int unsigned           cycle_count = 0;
  // expected slot_valid bits and slot contents
  logic [3:0]            exp_slots;
  logic [63:0]           exp_res [4];

  tb_clk_gen clk_gen_i (
    .clk   (clk),
    .reset (reset)
  );

  muldiv_top dut_i (
    .clk      (clk),
    .reset    (reset),
    .apb_req  (apb_req),
    .apb_resp (apb_resp)
  );

  // --------------------
  // failure and timeout
  // --------------------

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "stopping at first error");
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      fail_run($sformatf("timeout, no finish after %0d cycles", TIMEOUT_CYCLES));
    end
  end

  // --------------------
  // compare tasks
  // --------------------

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      fail_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_status(input string name, input muldiv_pkg::status_t exp,
                              input muldiv_pkg::status_t act);
    if (act !== exp) begin
      fail_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_result(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      fail_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
    end
  endtask

  // --------------------
  // stimulus helpers
  // --------------------

  // Galois form, shifts right, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // one LFSR step per bit taken
  task automatic rand_bits(input int n, output logic [31:0] w);
    int i;
    w = '0;
    for (i = 0; i < n; i++) begin
      w = {w[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // product as signed or unsigned 64-bit arithmetic
  function automatic logic [63:0] ref_mul(input muldiv_pkg::muldiv_op_e op,
                                          input logic [31:0] a, input logic [31:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [63:0]        p;
    if (op == muldiv_pkg::OP_MUL) begin
      sa = {{32{a[31]}}, a};
      sb = {{32{b[31]}}, b};
      p = sa * sb;
    end else begin
      p = {32'b0, a} * {32'b0, b};
    end
    return p;
  endfunction

  // quotient rounds toward zero, remainder takes the dividend sign
  // zero divisor: all ones quotient, dividend as remainder
  function automatic logic [63:0] ref_div(input muldiv_pkg::muldiv_op_e op,
                                          input logic [31:0] a, input logic [31:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [63:0]        q;
    logic [63:0]        r;
    if (b == 32'd0) begin
      return {a, 32'hFFFF_FFFF};
    end
    if (op == muldiv_pkg::OP_DIV) begin
      sa = {{32{a[31]}}, a};
      sb = {{32{b[31]}}, b};
      q = sa / sb;
      r = sa % sb;
    end else begin
      q = {32'b0, a} / {32'b0, b};
      r = {32'b0, a} % {32'b0, b};
    end
    return {r[31:0], q[31:0]};
  endfunction

  function automatic muldiv_pkg::status_t make_status(input logic div_busy, input logic mul_busy,
                                                      input logic [3:0] slots);
    muldiv_pkg::status_t s;
    s = '0;
    s.div_busy = div_busy;
    s.mul_busy = mul_busy;
    s.slot_valid = slots;
    return s;
  endfunction

  function automatic logic [31:0] cmd_word(input muldiv_pkg::muldiv_op_e op,
                                           input muldiv_pkg::tag_t tag);
    return {26'b0, tag, 2'b00, op};
  endfunction

  // --------------------
  // APB driver
  // --------------------

  // entered 1 ns after an edge, returns 1 ns after the access edge
  task automatic apb_access(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    // response is combinational, settled by mid-cycle
    @(negedge clk);
    rdata = apb_resp.prdata;
    err = apb_resp.pslverr;
    // no wait states, so the access phase always completes
    if (apb_resp.pready !== 1'b1) begin
      fail_run($sformatf("Error: pready expected %h actual %h", 1'b1, apb_resp.pready));
    end
    @(posedge clk);
    #1;
    apb_req = '0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    apb_access(1'b0, addr, 32'b0, data, err);
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    logic err;
    apb_write(addr, data, err);
    if (err) begin
      fail_run($sformatf("unexpected pslverr on write to address %h", addr));
    end
  endtask

  task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
    logic err;
    apb_read(addr, data, err);
    if (err) begin
      fail_run($sformatf("unexpected pslverr on read of address %h", addr));
    end
  endtask

  // --------------------
  // command level
  // --------------------

  task automatic issue_cmd(input muldiv_pkg::muldiv_op_e op, input muldiv_pkg::tag_t tag,
                           input logic [31:0] a, input logic [31:0] b);
    reg_write(muldiv_pkg::ADDR_OPA, a);
    reg_write(muldiv_pkg::ADDR_OPB, b);
    reg_write(muldiv_pkg::ADDR_CMD, cmd_word(op, tag));
    exp_slots[tag] = 1'b0;
  endtask

  // poll status until every slot in mask is valid
  task automatic wait_slots(input logic [3:0] mask, output muldiv_pkg::status_t st);
    logic [31:0] data;
    do begin
      reg_read(muldiv_pkg::ADDR_STATUS, data);
      st = data;
    end while ((st.slot_valid & mask) != mask);
    exp_slots = exp_slots | mask;
  endtask

  task automatic check_slot(input muldiv_pkg::tag_t tag);
    logic [31:0] lo;
    logic [31:0] hi;
    reg_read(muldiv_pkg::ADDR_RES_BASE + 8'(8 * tag), lo);
    reg_read(muldiv_pkg::ADDR_RES_BASE + 8'(8 * tag + 4), hi);
    check_result($sformatf("result[%0d]", tag), exp_res[tag], {hi, lo});
  endtask

  // divide and multiply launched back to back, then both slots checked
  task automatic run_pair(input muldiv_pkg::muldiv_op_e dop, input logic [31:0] da,
                          input logic [31:0] db, input muldiv_pkg::muldiv_op_e mop,
                          input logic [31:0] ma, input logic [31:0] mb,
                          input muldiv_pkg::tag_t dtag, input muldiv_pkg::tag_t mtag);
    muldiv_pkg::status_t st;
    issue_cmd(dop, dtag, da, db);
    issue_cmd(mop, mtag, ma, mb);
    exp_res[dtag] = ref_div(dop, da, db);
    exp_res[mtag] = ref_mul(mop, ma, mb);
    wait_slots((4'b0001 << dtag) | (4'b0001 << mtag), st);
    // both results landed, so both units are idle again
    check_status("status", make_status(1'b0, 1'b0, exp_slots), st);
    check_slot(dtag);
    check_slot(mtag);
  endtask

  // --------------------
  // tests
  // --------------------

  task automatic test_reset;
    logic [31:0] data;
    logic        err;
    reg_read(muldiv_pkg::ADDR_STATUS, data);
    check_status("status", make_status(1'b0, 1'b0, 4'b0000), data);
    apb_read(8'h10, data, err);
    if (!err) begin
      fail_run("read of unmapped address 0x10 returned no pslverr");
    end
    apb_write(8'h40, 32'h1, err);
    if (!err) begin
      fail_run("write to unmapped address 0x40 returned no pslverr");
    end
    reg_write(muldiv_pkg::ADDR_OPA, 32'h5a5a_c3c3);
    reg_read(muldiv_pkg::ADDR_OPA, data);
    check_word("opa", 32'h5a5a_c3c3, data);
  endtask

  task automatic test_unsigned;
    logic [31:0] ca [4];
    logic [31:0] cb [4];
    logic [31:0] a;
    logic [31:0] b;
    int          i;
    ca = '{32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0000, 32'h0000_0005};
    cb = '{32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0007, 32'h0001_0000};
    for (i = 0; i < 4; i++) begin
      run_pair(muldiv_pkg::OP_DIVU, ca[i], cb[i], muldiv_pkg::OP_MULU, ca[i], cb[i], 2'd0, 2'd1);
    end
    // short divisors keep the quotients interesting
    for (i = 0; i < 4; i++) begin
      rand_bits(32, a);
      rand_bits(12, b);
      b = b | 32'd1;
      run_pair(muldiv_pkg::OP_DIVU, a, b, muldiv_pkg::OP_MULU, a, b, 2'd0, 2'd1);
    end
  endtask

  task automatic test_signed;
    logic [31:0] ca [5];
    logic [31:0] cb [5];
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] s;
    int          i;
    // +1000/+37, +1000/-37, -1000/+37, -1000/-37, most negative by -1
    ca = '{32'd1000, 32'd1000, 32'hFFFF_FC18, 32'hFFFF_FC18, 32'h8000_0000};
    cb = '{32'd37, 32'hFFFF_FFDB, 32'd37, 32'hFFFF_FFDB, 32'hFFFF_FFFF};
    for (i = 0; i < 5; i++) begin
      run_pair(muldiv_pkg::OP_DIV, ca[i], cb[i], muldiv_pkg::OP_MUL, ca[i], cb[i], 2'd2, 2'd3);
    end
    rand_bits(32, a);
    rand_bits(16, b);
    rand_bits(1, s);
    b = b | 32'd1;
    if (s[0]) begin
      b = -b;
    end
    run_pair(muldiv_pkg::OP_DIV, a, b, muldiv_pkg::OP_MUL, a, b, 2'd2, 2'd3);
  endtask

  task automatic test_div_zero;
    logic [31:0] a;
    rand_bits(32, a);
    run_pair(muldiv_pkg::OP_DIVU, a, 32'd0, muldiv_pkg::OP_MULU, a, 32'd0, 2'd0, 2'd1);
    // -13 by zero keeps the negative dividend as remainder
    run_pair(muldiv_pkg::OP_DIV, 32'hFFFF_FFF3, 32'd0, muldiv_pkg::OP_MUL, 32'hFFFF_FFF3,
             32'd0, 2'd0, 2'd1);
  endtask

  task automatic test_concurrency;
    run_pair(muldiv_pkg::OP_DIV, 32'h7FFF_FFFF, 32'hFFFF_FFFE, muldiv_pkg::OP_MULU,
             32'hDEAD_BEEF, 32'hCAFE_F00D, 2'd2, 2'd3);
  endtask

  // second divide while the first runs is dropped, slot 1 keeps its old result
  task automatic test_busy_drop;
    muldiv_pkg::status_t st;
    logic [31:0]         data;
    logic                err;
    issue_cmd(muldiv_pkg::OP_DIVU, 2'd0, 32'd1000003, 32'd97);
    exp_res[0] = ref_div(muldiv_pkg::OP_DIVU, 32'd1000003, 32'd97);
    reg_read(muldiv_pkg::ADDR_STATUS, data);
    check_status("status", make_status(1'b1, 1'b0, exp_slots), data);
    apb_write(muldiv_pkg::ADDR_CMD, cmd_word(muldiv_pkg::OP_DIV, 2'd1), err);
    if (!err) begin
      fail_run("divide issued while div_busy was set returned no pslverr");
    end
    reg_read(muldiv_pkg::ADDR_CMD, data);
    check_word("cmd", cmd_word(muldiv_pkg::OP_DIVU, 2'd0), data);
    wait_slots(4'b0001, st);
    check_status("status", make_status(1'b0, 1'b0, exp_slots), st);
    check_slot(2'd0);
    check_slot(2'd1);
  endtask

  task automatic test_reissue;
    muldiv_pkg::status_t st;
    logic [31:0]         data;
    // -7 * 123457 into the slot that is still valid
    issue_cmd(muldiv_pkg::OP_MUL, 2'd0, 32'hFFFF_FFF9, 32'd123457);
    exp_res[0] = ref_mul(muldiv_pkg::OP_MUL, 32'hFFFF_FFF9, 32'd123457);
    reg_read(muldiv_pkg::ADDR_STATUS, data);
    check_status("status", make_status(1'b0, 1'b1, exp_slots), data);
    wait_slots(4'b0001, st);
    check_status("status", make_status(1'b0, 1'b0, exp_slots), st);
    check_slot(2'd0);
  endtask

  // --------------------
  // main sequence
  // --------------------

  initial begin
    apb_req = '0;
    exp_slots = '0;
    @(negedge reset);
    test_reset();
    test_unsigned();
    test_signed();
    test_div_zero();
    test_concurrency();
    test_busy_drop();
    test_reissue();
    $display("Verification passed");
    $finish;
  end

endmodule

// ==== list.f ====
hw/muldiv_pkg.sv
hw/int_div_iterative.sv
hw/int_mul_iterative.sv
hw/wb_arbiter.sv
hw/muldiv_apb_regs.sv
hw/muldiv_top.sv
tb/tb_clk_gen.sv
tb/tb_muldiv.sv

// ==== Bender.yml ====
package:
  name: muldiv

sources:
  - hw/muldiv_pkg.sv
  - hw/int_div_iterative.sv
  - hw/int_mul_iterative.sv
  - hw/wb_arbiter.sv
  - hw/muldiv_apb_regs.sv
  - hw/muldiv_top.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_muldiv.sv
